// File: flist.f
+incdir+.
fpcvt_pkg.sv
fp_lzc.sv
fp_i2f.sv
fp_f2f.sv
fp_rnd.sv
fpcvt_top.sv
fpcvt_checker.sv
fpcvt_tb.sv

// File: fp_f2f.sv
`timescale 1ns/1ps
`include "fpcvt_settings.svh"

module fp_f2f (
    input  fpcvt_pkg::fp_fmt_e    fmt_i,
    input  logic [`FP_XLEN-1:0]   operand_i,
    output logic                  sig_o,
    output logic [`FP_EXPW-1:0]   expo_o,
    output logic [`FP_MANTW-1:0]  mant_o,
    output logic [1:0]            rema_o,
    output logic [2:0]            grs_o,
    output logic                  snan_o,
    output logic                  qnan_o,
    output logic                  infs_o,
    output logic                  zero_o
);

    fpcvt_pkg::fp_operand_u       src;
    logic                         widen;      // single source to double
    logic [10:0]                  src_exp;
    logic                         exp_max;
    logic                         exp_min;
    logic                         frac_msb;   // quiet bit
    logic [`FP_XLEN-1:0]          lz_word;
    logic [6:0]                   lz_cnt;
    logic                         frac_zero;
    logic [`FP_XLEN-1:0]          sub_norm;
    logic signed [`FP_EXPW-1:0]   reb;        // exponent rebiased to single
    logic signed [`FP_EXPW-1:0]   rsh;
    logic [5:0]                   shc;
    logic [`FP_XLEN-1:0]          ext;
    logic [2*`FP_XLEN-1:0]        wide;

    assign src   = operand_i;
    assign widen = (fmt_i == fpcvt_pkg::FMT_D);

    // fraction left aligned, shared by zero test and subnormal normalize
    assign lz_word = widen ? {src.s.frac, 41'b0} : {src.d.frac, 12'b0};

    fp_lzc u_lzc (
        .data_i (lz_word),
        .cnt_o  (lz_cnt),
        .zero_o (frac_zero)
    );

    assign src_exp  = widen ? {3'b0, src.s.expo} : src.d.expo;
    assign exp_max  = widen ? (src.s.expo == 8'hFF) : (src.d.expo == 11'h7FF);
    assign exp_min  = (src_exp == 11'd0);
    assign frac_msb = widen ? src.s.frac[22] : src.d.frac[51];

    assign sig_o  = widen ? src.s.sign : src.d.sign;
    assign snan_o = exp_max & ~frac_zero & ~frac_msb;
    assign qnan_o = exp_max & frac_msb;
    assign infs_o = exp_max & frac_zero;
    assign zero_o = exp_min & frac_zero;
    assign rema_o = 2'b00;

    assign sub_norm = lz_word << lz_cnt;  // single subnormal, hidden one at bit 63

    // narrowing path
    assign reb = $signed({3'b0, (exp_min ? 11'd1 : src_exp)})
               - `FP_EXPW'(`FP_BIAS_D - `FP_BIAS_S);
    assign rsh = `FP_EXPW'sd1 - reb;
    assign ext = {~exp_min, src.d.frac, 11'b0};

    always_comb begin
        if (reb > 0) begin
            shc = 6'd0;
        end else if (rsh > 63) begin
            shc = 6'd63;          // everything lands in sticky anyway
        end else begin
            shc = rsh[5:0];
        end
    end

    assign wide = {ext, 64'b0} >> shc;  // low half collects the lost bits

    always_comb begin
        if (widen) begin
            grs_o = 3'b000;                  // always exact
            if (exp_min) begin
                expo_o = `FP_EXPW'(`FP_BIAS_D - `FP_BIAS_S) - {7'b0, lz_cnt};
                mant_o = {2'b01, sub_norm[62:40], 29'b0};
            end else begin
                expo_o = {6'b0, src.s.expo} + `FP_EXPW'(`FP_BIAS_D - `FP_BIAS_S);
                mant_o = {2'b01, src.s.frac, 29'b0};
            end
        end else begin
            expo_o = (reb > 0) ? reb : '0;   // large values overflow in fp_rnd
            mant_o = {30'b0, wide[127:104]};
            grs_o  = {wide[103], wide[102], (|wide[101:64]) | (|wide[63:0])};
        end
    end

endmodule

// File: fp_i2f.sv
`timescale 1ns/1ps
`include "fpcvt_settings.svh"

module fp_i2f (
    input  fpcvt_pkg::cvt_op_e    op_i,
    input  fpcvt_pkg::fp_fmt_e    fmt_i,
    input  logic [`FP_XLEN-1:0]   operand_i,
    output logic                  sig_o,
    output logic [`FP_EXPW-1:0]   expo_o,
    output logic [`FP_MANTW-1:0]  mant_o,
    output logic [1:0]            rema_o,
    output logic [2:0]            grs_o,
    output logic                  zero_o
);

    logic [`FP_XLEN-1:0]  ival;
    logic [`FP_XLEN-1:0]  mag;
    logic [`FP_XLEN-1:0]  norm;
    logic [6:0]           lz_cnt;
    logic [`FP_EXPW-1:0]  top_exp;   // biased exponent of bit 63
    logic                 to_d;

    assign ival = (op_i == fpcvt_pkg::CVT_W2F) ?
                  {{32{operand_i[31]}}, operand_i[31:0]} : operand_i;
    assign sig_o = ival[`FP_XLEN-1];
    assign mag   = sig_o ? (~ival + 64'd1) : ival;  // -2^63 stays 2^63 unsigned

    fp_lzc u_lzc (
        .data_i (mag),
        .cnt_o  (lz_cnt),
        .zero_o (zero_o)
    );

    assign norm = mag << lz_cnt;  // leading one now at bit 63
    assign to_d = (fmt_i == fpcvt_pkg::FMT_D);

    assign top_exp = to_d ? `FP_EXPW'(63 + `FP_BIAS_D) : `FP_EXPW'(63 + `FP_BIAS_S);
    assign expo_o  = top_exp - {7'b0, lz_cnt};

    always_comb begin
        if (to_d) begin
            mant_o = {1'b0, norm[63:11]};            // 53 bits with hidden one
            grs_o  = {norm[10], norm[9], |norm[8:0]};
        end else begin
            mant_o = {30'b0, norm[63:40]};           // 24 bits with hidden one
            grs_o  = {norm[39], norm[38], |norm[37:0]};
        end
    end

    assign rema_o = 2'b00;

endmodule

// File: fp_lzc.sv
`timescale 1ns/1ps
`include "fpcvt_settings.svh"

module fp_lzc (
    input  logic [`FP_XLEN-1:0] data_i,
    output logic [6:0]          cnt_o,
    output logic                zero_o
);

    logic [`FP_XLEN-1:0] s32;
    logic [`FP_XLEN-1:0] s16;
    logic [`FP_XLEN-1:0] s8;
    logic [`FP_XLEN-1:0] s4;
    logic [`FP_XLEN-1:0] s2;
    logic [5:0]          c;

    // binary search, halving the window each level
    assign c[5] = ~|data_i[63:32];
    assign s32  = c[5] ? {data_i[31:0], 32'b0} : data_i;
    assign c[4] = ~|s32[63:48];
    assign s16  = c[4] ? {s32[47:0], 16'b0} : s32;
    assign c[3] = ~|s16[63:56];
    assign s8   = c[3] ? {s16[55:0], 8'b0} : s16;
    assign c[2] = ~|s8[63:60];
    assign s4   = c[2] ? {s8[59:0], 4'b0} : s8;
    assign c[1] = ~|s4[63:62];
    assign s2   = c[1] ? {s4[61:0], 2'b0} : s4;
    assign c[0] = ~s2[63];

    assign zero_o = ~|data_i;
    assign cnt_o  = zero_o ? 7'd64 : {1'b0, c};  // all zero counts as full width

endmodule

// File: fp_rnd.sv
`timescale 1ns/1ps
`include "fpcvt_settings.svh"

module fp_rnd (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  valid_i,
    input  logic                  sig_i,
    input  logic [`FP_EXPW-1:0]   expo_i,
    input  logic [`FP_MANTW-1:0]  mant_i,
    input  logic [1:0]            rema_i,
    input  fpcvt_pkg::fp_fmt_e    fmt_i,
    input  fpcvt_pkg::rnd_mode_e  rm_i,
    input  logic [2:0]            grs_i,
    input  logic                  snan_i,
    input  logic                  qnan_i,
    input  logic                  dbz_i,
    input  logic                  infs_i,
    input  logic                  zero_i,
    input  logic                  diff_i,
    output logic [`FP_XLEN-1:0]   result_o,
    output logic [4:0]            flags_o,
    output logic                  ready_o
);

    logic                         valid_r;
    logic                         sig_r;
    logic signed [`FP_EXPW-1:0]   expo_r;
    logic [`FP_MANTW-1:0]         mant_r;
    logic [1:0]                   rema_r;
    fpcvt_pkg::fp_fmt_e           fmt_r;
    fpcvt_pkg::rnd_mode_e         rm_r;
    logic [2:0]                   grs_r;
    logic                         snan_r;
    logic                         qnan_r;
    logic                         dbz_r;
    logic                         infs_r;
    logic                         zero_r;
    logic                         diff_r;

    // all cleared so the packed word reads zero after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_r <= 1'b0;
            sig_r   <= 1'b0;
            expo_r  <= '0;
            mant_r  <= '0;
            rema_r  <= 2'b00;
            fmt_r   <= fpcvt_pkg::FMT_S;
            rm_r    <= fpcvt_pkg::RNE;
            grs_r   <= 3'b000;
            snan_r  <= 1'b0;
            qnan_r  <= 1'b0;
            dbz_r   <= 1'b0;
            infs_r  <= 1'b0;
            zero_r  <= 1'b0;
            diff_r  <= 1'b0;
        end else begin
            valid_r <= valid_i;
            sig_r   <= sig_i;
            expo_r  <= expo_i;
            mant_r  <= mant_i;
            rema_r  <= rema_i;
            fmt_r   <= fmt_i;
            rm_r    <= rm_i;
            grs_r   <= grs_i;
            snan_r  <= snan_i;
            qnan_r  <= qnan_i;
            dbz_r   <= dbz_i;
            infs_r  <= infs_i;
            zero_r  <= zero_i;
            diff_r  <= diff_i;
        end
    end

    logic                         is_d;
    logic                         sign;
    logic                         inexact;
    logic                         lsb_odd;
    logic                         rnd_up;
    logic                         rnd_dn;   // truncating direction, clamps on overflow
    logic                         frac_nil;
    logic signed [`FP_EXPW-1:0]   e_max;    // largest finite biased exponent
    logic signed [`FP_EXPW-1:0]   e_fin;
    logic [`FP_MANTW-1:0]         m_fin;
    logic [10:0]                  pk_exp;
    logic [51:0]                  pk_frac;
    logic [4:0]                   fl;

    always_comb begin
        is_d    = (fmt_r == fpcvt_pkg::FMT_D);
        e_max   = is_d ? `FP_EXPW'(2 * `FP_BIAS_D) : `FP_EXPW'(2 * `FP_BIAS_S);
        sign    = sig_r;
        inexact = (rema_r != 2'b00) || (grs_r != 3'b000);
        lsb_odd = mant_r[0] || (grs_r[1:0] != 2'b00) || (rema_r == 2'b01);

        rnd_up = 1'b0;
        rnd_dn = 1'b0;
        case (rm_r)
            fpcvt_pkg::RNE: rnd_up = grs_r[2] && lsb_odd;
            fpcvt_pkg::RTZ: rnd_dn = 1'b1;
            fpcvt_pkg::RDN: begin
                if (sig_r) begin
                    rnd_up = inexact;
                end else if (zero_r && diff_r) begin
                    sign = 1'b1;            // exact x - x gives -0 here
                end else begin
                    rnd_dn = 1'b1;
                end
            end
            fpcvt_pkg::RUP: begin
                if (!sig_r) begin
                    rnd_up = inexact;
                end else begin
                    rnd_dn = 1'b1;
                end
            end
            fpcvt_pkg::RMM: rnd_up = grs_r[2];
            default: rnd_up = 1'b0;
        endcase

        m_fin = mant_r + {{(`FP_MANTW-1){1'b0}}, rnd_up};
        e_fin = expo_r;

        // subnormal that rounded up into the smallest normal
        if (rnd_up && e_fin == 0 && (is_d ? m_fin[52] : m_fin[23])) begin
            e_fin = `FP_EXPW'sd1;
        end

        // carry past the hidden one
        if (is_d ? m_fin[53] : m_fin[24]) begin
            m_fin = m_fin >> 1;
            e_fin = e_fin + `FP_EXPW'sd1;
        end

        frac_nil = is_d ? (m_fin[51:0] == '0) : (m_fin[22:0] == '0);

        fl = '0;
        fl[`FLAG_NX] = inexact;
        if (e_fin == 0) begin
            fl[`FLAG_UF] = inexact;
        end else if (rnd_up && e_fin == `FP_EXPW'sd1 && frac_nil) begin
            // tiny unless rounding with unbounded exponent reached 2^emin too
            if (rm_r == fpcvt_pkg::RDN || rm_r == fpcvt_pkg::RUP) begin
                fl[`FLAG_UF] = (grs_r != 3'b000) && !(grs_r[2] && (grs_r[1:0] != 2'b00));
            end else begin
                fl[`FLAG_UF] = grs_r[2] && !grs_r[1];
            end
        end

        pk_exp  = e_fin[10:0];
        pk_frac = is_d ? m_fin[51:0] : {29'b0, m_fin[22:0]};
        if (snan_r || qnan_r) begin
            sign    = 1'b0;                 // canonical NaN
            pk_exp  = is_d ? 11'h7FF : 11'h0FF;
            pk_frac = is_d ? {1'b1, 51'b0} : {29'b0, 1'b1, 22'b0};
            fl      = snan_r ? 5'(1 << `FLAG_NV) : 5'b00000;
        end else if (dbz_r || infs_r) begin
            pk_exp  = is_d ? 11'h7FF : 11'h0FF;
            pk_frac = '0;
            fl      = dbz_r ? 5'(1 << `FLAG_DZ) : 5'b00000;
        end else if (zero_r) begin
            pk_exp  = '0;
            pk_frac = '0;
            fl      = 5'b00000;
        end else if (e_fin > e_max) begin
            if (rnd_dn) begin               // largest finite
                pk_exp  = e_max[10:0];
                pk_frac = is_d ? {52{1'b1}} : {29'b0, {23{1'b1}}};
            end else begin
                pk_exp  = is_d ? 11'h7FF : 11'h0FF;
                pk_frac = '0;
            end
            fl = 5'((1 << `FLAG_OF) | (1 << `FLAG_NX));
        end
    end

    assign result_o = is_d ? {sign, pk_exp, pk_frac}
                           : {32'b0, sign, pk_exp[7:0], pk_frac[22:0]};
    assign flags_o  = fl;
    assign ready_o  = valid_r;

endmodule

// File: fpcvt_checker.sv
`timescale 1ns/1ps
`include "fpcvt_settings.svh"

module fpcvt_checker (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                valid_i,
    input  logic [1:0]          fmt_i,
    input  logic                valid_o,
    input  logic [`FP_XLEN-1:0] result_o,
    input  logic [4:0]          flags_o
);

    int unsigned fail_cnt;  // count of failed assertions

    initial fail_cnt = 0;

    // output stage is cleared while reset is held
    reset_quiet: assert property (@(posedge clk) !rst_n |-> !valid_o)
        else begin
            $error("valid_o high while in reset");
            fail_cnt = fail_cnt + 1;
        end

    // one cycle latency, no stalls
    valid_follows: assert property (@(posedge clk) disable iff (!rst_n)
        valid_o == $past(valid_i))
        else begin
            $error("valid_o does not follow valid_i by one cycle");
            fail_cnt = fail_cnt + 1;
        end

    ovf_inexact: assert property (@(posedge clk) disable iff (!rst_n)
        valid_o && flags_o[`FLAG_OF] |-> flags_o[`FLAG_NX])
        else begin
            $error("overflow flag without inexact flag");
            fail_cnt = fail_cnt + 1;
        end

    single_upper: assert property (@(posedge clk) disable iff (!rst_n)
        valid_o && ($past(fmt_i) == fpcvt_pkg::FMT_S) |-> result_o[63:32] == '0)
        else begin
            $error("single result with nonzero upper half");
            fail_cnt = fail_cnt + 1;
        end

endmodule

bind fpcvt_top fpcvt_checker u_checker (
    .clk      (clk),
    .rst_n    (rst_n),
    .valid_i  (valid_i),
    .fmt_i    (fmt_i),
    .valid_o  (valid_o),
    .result_o (result_o),
    .flags_o  (flags_o)
);

// File: fpcvt_pkg.sv
package fpcvt_pkg;

    // single precision, sitting in the low half of the operand word
    typedef struct packed {
        logic [31:0] pad;   // ignored upper half
        logic        sign;
        logic [7:0]  expo;
        logic [22:0] frac;
    } fp_single_t;

    typedef struct packed {
        logic        sign;
        logic [10:0] expo;
        logic [51:0] frac;
    } fp_double_t;

    // one 64-bit word seen either way
    typedef union packed {
        fp_single_t s;
        fp_double_t d;
    } fp_operand_u;

    typedef enum logic [1:0] {
        CVT_W2F = 2'd0,  // int32 in the low half
        CVT_L2F = 2'd1,  // int64
        CVT_F2F = 2'd2   // other format to fmt
    } cvt_op_e;

    typedef enum logic [2:0] {
        RNE = 3'd0,
        RTZ = 3'd1,
        RDN = 3'd2,
        RUP = 3'd3,
        RMM = 3'd4
    } rnd_mode_e;

    typedef enum logic [1:0] {
        FMT_S = 2'd0,
        FMT_D = 2'd1
    } fp_fmt_e;

endpackage

// File: fpcvt_settings.svh
`ifndef FPCVT_SETTINGS_SVH
`define FPCVT_SETTINGS_SVH

// operand and result word
`define FP_XLEN   64

// internal signed exponent, wide enough for rebias of either format
`define FP_EXPW   14

// internal mantissa incl. carry bit above the hidden one
`define FP_MANTW  54

`define FP_BIAS_S 127
`define FP_BIAS_D 1023

// flag bit positions
`define FLAG_NX   0  // inexact
`define FLAG_UF   1  // underflow
`define FLAG_OF   2  // overflow
`define FLAG_DZ   3  // divide by zero
`define FLAG_NV   4  // invalid

`endif

// File: fpcvt_tb.sv
`timescale 1ns/1ps
`include "fpcvt_settings.svh"

module fpcvt_tb;

    localparam int CLK_PERIOD = 40;
    localparam int N_RAND     = 6;   // random values per op and format
    localparam int N_CONV     = 4 * (N_RAND + 1) + 10 + 4 + 2 + 3 + 2;

    logic                  clk;
    logic                  rst_n;
    logic                  valid_i;
    fpcvt_pkg::cvt_op_e    op_i;
    fpcvt_pkg::fp_fmt_e    fmt_i;
    fpcvt_pkg::rnd_mode_e  rm_i;
    logic [`FP_XLEN-1:0]   operand_i;
    logic                  valid_o;
    logic [`FP_XLEN-1:0]   result_o;
    logic [4:0]            flags_o;
    integer                seed;

    fpcvt_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_i   (valid_i),
        .op_i      (op_i),
        .fmt_i     (fmt_i),
        .rm_i      (rm_i),
        .operand_i (operand_i),
        .valid_o   (valid_o),
        .result_o  (result_o),
        .flags_o   (flags_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // two cycles per conversion plus slack
    initial begin
        repeat (N_CONV * 2 + 200) @(posedge clk);
        $display("Watchdog expired, the tests did not finish in time");
        $display("Errors found");
        $fatal(1, "timeout");
    end

    // a failed bound assertion ends the run as a failure
    initial begin
        wait (u_dut.u_checker.fail_cnt != 0);
        $display("Assertion in fpcvt_checker failed, see the message above");
        $display("Errors found");
        $fatal(1, "assertion");
    end

    task automatic check_val(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
        if (expected !== actual) begin
            $display("Error %s: expected %h, actual %h", name, expected, actual);
            $display("Errors found");
            $fatal(1, "mismatch");
        end
    endtask

    function automatic logic [63:0] make_single(input logic sign, input logic [7:0] expo,
                                                input logic [22:0] frac);
        fpcvt_pkg::fp_operand_u u;
        u        = '0;
        u.s.sign = sign;
        u.s.expo = expo;
        u.s.frac = frac;
        return u;
    endfunction

    function automatic logic [63:0] make_double(input logic sign, input logic [10:0] expo,
                                                input logic [51:0] frac);
        fpcvt_pkg::fp_operand_u u;
        u.d.sign = sign;
        u.d.expo = expo;
        u.d.frac = frac;
        return u;
    endfunction

    // exact value for magnitudes below 2^24
    function automatic logic [63:0] int_to_fp(input logic signed [63:0] v, input logic to_d);
        logic [63:0] mag;
        logic [63:0] frac;
        int          msb;
        int          i;
        int_to_fp = '0;
        msb       = 0;
        if (v != 0) begin
            mag = (v < 0) ? -v : v;
            for (i = 0; i < 64; i++) begin
                if (mag[i]) msb = i;
            end
            frac = mag << (63 - msb);  // leading one at bit 63
            if (to_d) begin
                int_to_fp = {v[63], 11'(msb + `FP_BIAS_D), frac[62:11]};
            end else begin
                int_to_fp = {32'd0, v[63], 8'(msb + `FP_BIAS_S), frac[62:40]};
            end
        end
    endfunction

    task automatic apply_cvt(input string name, input fpcvt_pkg::cvt_op_e op,
                             input fpcvt_pkg::fp_fmt_e fmt, input fpcvt_pkg::rnd_mode_e rm,
                             input logic [63:0] operand, input logic [63:0] exp_res,
                             input logic [4:0] exp_flags);
        @(negedge clk);
        valid_i   = 1'b1;
        op_i      = op;
        fmt_i     = fmt;
        rm_i      = rm;
        operand_i = operand;
        @(posedge clk);
        @(negedge clk);  // outputs settled from the stage registers
        valid_i = 1'b0;
        check_val({name, " valid"}, 64'd1, valid_o);
        check_val({name, " result"}, exp_res, result_o);
        check_val({name, " flags"}, exp_flags, flags_o);
    endtask

    task automatic int_exact_conversions();
        logic signed [63:0] v;
        logic [63:0]        opnd;
        integer             r;
        int                 oi;
        int                 fi;
        int                 n;
        for (oi = 0; oi < 2; oi++) begin
            for (fi = 0; fi < 2; fi++) begin
                for (n = 0; n <= N_RAND; n++) begin
                    r = (n == N_RAND) ? 0 : $random(seed) % (1 << 24);
                    v = r;
                    if (oi == 0) begin
                        opnd = {$random(seed), v[31:0]};  // upper half is ignored
                    end else begin
                        opnd = v;
                    end
                    apply_cvt($sformatf("int_exact op%0d fmt%0d val %0d", oi, fi, r),
                              (oi == 0) ? fpcvt_pkg::CVT_W2F : fpcvt_pkg::CVT_L2F,
                              (fi == 0) ? fpcvt_pkg::FMT_S : fpcvt_pkg::FMT_D,
                              fpcvt_pkg::rnd_mode_e'(n % 5), opnd, int_to_fp(v, fi == 1), 5'd0);
                end
            end
        end
    endtask

    task automatic rounding_mode_ties();
        logic signed [63:0] v;
        logic               neg;
        logic               away;
        int                 s;
        int                 m;
        for (s = 0; s < 2; s++) begin
            for (m = 0; m < 5; m++) begin
                neg = (s == 1);
                v   = neg ? -64'sd16777217 : 64'sd16777217;  // 2^24 + 1, a tie
                case (fpcvt_pkg::rnd_mode_e'(m))
                    fpcvt_pkg::RUP: away = !neg;
                    fpcvt_pkg::RDN: away = neg;
                    fpcvt_pkg::RMM: away = 1'b1;
                    default:        away = 1'b0;  // RNE picks the even 2^24
                endcase
                apply_cvt($sformatf("round sign%0d mode%0d", s, m), fpcvt_pkg::CVT_W2F,
                          fpcvt_pkg::FMT_S, fpcvt_pkg::rnd_mode_e'(m), {32'd0, v[31:0]},
                          make_single(neg, 8'(24 + `FP_BIAS_S), {22'd0, away}),
                          5'(1 << `FLAG_NX));
            end
        end
    endtask

    task automatic widen_exact();
        apply_cvt("widen 1.5", fpcvt_pkg::CVT_F2F, fpcvt_pkg::FMT_D, fpcvt_pkg::RNE,
                  make_single(0, 8'd127, 23'h400000), make_double(0, 11'd1023, 52'h8 << 48), 5'd0);
        apply_cvt("widen -0", fpcvt_pkg::CVT_F2F, fpcvt_pkg::FMT_D, fpcvt_pkg::RNE,
                  make_single(1, 8'd0, 23'd0), make_double(1, 11'd0, 52'd0), 5'd0);
        apply_cvt("widen inf", fpcvt_pkg::CVT_F2F, fpcvt_pkg::FMT_D, fpcvt_pkg::RUP,
                  make_single(0, 8'd255, 23'd0), make_double(0, 11'd2047, 52'd0), 5'd0);
        // -3 * 2^-149 is -1.5 * 2^-148
        apply_cvt("widen subnormal", fpcvt_pkg::CVT_F2F, fpcvt_pkg::FMT_D, fpcvt_pkg::RNE,
                  make_single(1, 8'd0, 23'd3),
                  make_double(1, 11'(`FP_BIAS_D - 148), 52'h8 << 48), 5'd0);
    endtask

    task automatic nan_canonical();
        apply_cvt("snan", fpcvt_pkg::CVT_F2F, fpcvt_pkg::FMT_D, fpcvt_pkg::RNE,
                  make_single(0, 8'd255, 23'd1), 64'h7FF8000000000000, 5'(1 << `FLAG_NV));
        apply_cvt("qnan", fpcvt_pkg::CVT_F2F, fpcvt_pkg::FMT_D, fpcvt_pkg::RNE,
                  make_single(1, 8'd255, 23'h400000), 64'h7FF8000000000000, 5'd0);
    endtask

    task automatic narrow_overflow();
        logic [63:0] big;
        logic [4:0]  ovf;
        big = make_double(0, 11'h7E3, 52'h7E43C8800759C);  // 1e300
        ovf = 5'((1 << `FLAG_OF) | (1 << `FLAG_NX));
        apply_cvt("ovf rne", fpcvt_pkg::CVT_F2F, fpcvt_pkg::FMT_S, fpcvt_pkg::RNE, big,
                  make_single(0, 8'd255, 23'd0), ovf);
        apply_cvt("ovf rtz", fpcvt_pkg::CVT_F2F, fpcvt_pkg::FMT_S, fpcvt_pkg::RTZ, big,
                  make_single(0, 8'd254, 23'h7FFFFF), ovf);
        apply_cvt("ovf rdn", fpcvt_pkg::CVT_F2F, fpcvt_pkg::FMT_S, fpcvt_pkg::RDN, big,
                  make_single(0, 8'd254, 23'h7FFFFF), ovf);
    endtask

    task automatic narrow_underflow();
        apply_cvt("tiny exact", fpcvt_pkg::CVT_F2F, fpcvt_pkg::FMT_S, fpcvt_pkg::RNE,
                  make_double(0, 11'(`FP_BIAS_D - 149), 52'd0), 64'h1, 5'd0);
        apply_cvt("tiny inexact", fpcvt_pkg::CVT_F2F, fpcvt_pkg::FMT_S, fpcvt_pkg::RNE,
                  make_double(0, 11'(`FP_BIAS_D - 150), 52'h8 << 48), 64'h1,
                  5'((1 << `FLAG_UF) | (1 << `FLAG_NX)));
    endtask

    initial begin
        seed      = 50678;
        rst_n     = 1'b0;
        valid_i   = 1'b0;
        op_i      = fpcvt_pkg::CVT_W2F;
        fmt_i     = fpcvt_pkg::FMT_S;
        rm_i      = fpcvt_pkg::RNE;
        operand_i = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_val("reset valid", 64'd0, valid_o);
        check_val("reset result", 64'd0, result_o);
        check_val("reset flags", 64'd0, flags_o);
        int_exact_conversions();
        rounding_mode_ties();
        widen_exact();
        nan_canonical();
        narrow_overflow();
        narrow_underflow();
        @(negedge clk);
        $display("No errors");
        $finish;
    end

endmodule

// File: fpcvt_top.sv
`timescale 1ns/1ps
`include "fpcvt_settings.svh"

module fpcvt_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  valid_i,
    input  fpcvt_pkg::cvt_op_e    op_i,
    input  fpcvt_pkg::fp_fmt_e    fmt_i,
    input  fpcvt_pkg::rnd_mode_e  rm_i,
    input  logic [`FP_XLEN-1:0]   operand_i,
    output logic                  valid_o,
    output logic [`FP_XLEN-1:0]   result_o,
    output logic [4:0]            flags_o
);

    logic                  i2f_sig;
    logic [`FP_EXPW-1:0]   i2f_expo;
    logic [`FP_MANTW-1:0]  i2f_mant;
    logic [1:0]            i2f_rema;
    logic [2:0]            i2f_grs;
    logic                  i2f_zero;

    logic                  f2f_sig;
    logic [`FP_EXPW-1:0]   f2f_expo;
    logic [`FP_MANTW-1:0]  f2f_mant;
    logic [1:0]            f2f_rema;
    logic [2:0]            f2f_grs;
    logic                  f2f_snan;
    logic                  f2f_qnan;
    logic                  f2f_infs;
    logic                  f2f_zero;

    logic                  use_f2f;

    fp_i2f u_i2f (
        .op_i      (op_i),
        .fmt_i     (fmt_i),
        .operand_i (operand_i),
        .sig_o     (i2f_sig),
        .expo_o    (i2f_expo),
        .mant_o    (i2f_mant),
        .rema_o    (i2f_rema),
        .grs_o     (i2f_grs),
        .zero_o    (i2f_zero)
    );

    fp_f2f u_f2f (
        .fmt_i     (fmt_i),
        .operand_i (operand_i),
        .sig_o     (f2f_sig),
        .expo_o    (f2f_expo),
        .mant_o    (f2f_mant),
        .rema_o    (f2f_rema),
        .grs_o     (f2f_grs),
        .snan_o    (f2f_snan),
        .qnan_o    (f2f_qnan),
        .infs_o    (f2f_infs),
        .zero_o    (f2f_zero)
    );

    assign use_f2f = (op_i == fpcvt_pkg::CVT_F2F);

    // integers never produce NaN or infinity
    fp_rnd u_rnd (
        .clk      (clk),
        .rst_n    (rst_n),
        .valid_i  (valid_i),
        .sig_i    (use_f2f ? f2f_sig  : i2f_sig),
        .expo_i   (use_f2f ? f2f_expo : i2f_expo),
        .mant_i   (use_f2f ? f2f_mant : i2f_mant),
        .rema_i   (use_f2f ? f2f_rema : i2f_rema),
        .fmt_i    (fmt_i),
        .rm_i     (rm_i),
        .grs_i    (use_f2f ? f2f_grs  : i2f_grs),
        .snan_i   (use_f2f & f2f_snan),
        .qnan_i   (use_f2f & f2f_qnan),
        .dbz_i    (1'b0),              // no division in a conversion
        .infs_i   (use_f2f & f2f_infs),
        .zero_i   (use_f2f ? f2f_zero : i2f_zero),
        .diff_i   (1'b0),
        .result_o (result_o),
        .flags_o  (flags_o),
        .ready_o  (valid_o)
    );

endmodule
